//--- hw/pers_pkg.sv
package pers_pkg;

   // --------------------------------------------------
   // Data widths
   // --------------------------------------------------

   // AEG word, also dispatch and CSR data
   typedef logic [63:0] aeg_data_t;
   // AEG index as sent by dispatch
   typedef logic [17:0] aeg_idx_t;
   // Memory virtual byte address
   typedef logic [47:0] vadr_t;
   // Event timestamp and GVT value
   typedef logic [15:0] gvt_t;
   // Record count of the event table
   typedef logic [31:0] ev_len_t;
   // Dispatch instruction code
   typedef logic [4:0]  inst_t;

   // Control FSM, encoding is what CSR_STATUS reports
   typedef enum logic [1:0] {
      ctl_idle     = 2'd0,
      ctl_running  = 2'd1,
      ctl_finished = 2'd2
   } ctl_state_t;

   // --------------------------------------------------
   // AEG map
   // --------------------------------------------------
   localparam int NUM_AEG       = 8;
   localparam int AEG_ADDR_BASE = 0;
   // Record count lives in the low 32 bits
   localparam int AEG_EV_LEN    = 3;
   localparam int AEG_GVT       = 4;

   // Dispatch and CSR codes
   localparam inst_t       INST_RUN   = 5'd0;
   localparam logic [15:0] CSR_STATUS = 16'h0;
   localparam logic [15:0] CSR_GVT    = 16'h1;

   // Memory controller command and size
   localparam logic [2:0] MC_CMD_RD  = 3'd1;
   localparam logic [1:0] MC_SIZE_64 = 2'd3;

   // Reported when the table holds no records
   localparam gvt_t GVT_EMPTY = '1;

endpackage

//--- hw/aeg_regs.sv
`timescale 1ns/1ps

module aeg_regs (
   input  logic                clk,
   input  logic                reset,
   // Dispatch register access
   input  pers_pkg::aeg_idx_t  disp_aeg_idx,
   input  logic                disp_aeg_rd,
   input  logic                disp_aeg_wr,
   input  pers_pkg::aeg_data_t disp_aeg_wr_data,
   // GVT write-back from control
   input  logic                gvt_wr_en,
   input  pers_pkg::gvt_t      gvt_wr_data,
   // Read return
   output logic                disp_rtn_data_vld,
   output pers_pkg::aeg_data_t disp_rtn_data,
   output logic                aeg_idx_err,
   // Run arguments for the engine
   output pers_pkg::vadr_t     aeg_base,
   output pers_pkg::ev_len_t   aeg_len
);

   localparam int IDX_W = $clog2(pers_pkg::NUM_AEG);

   pers_pkg::aeg_data_t aeg_q [pers_pkg::NUM_AEG];
   logic                idx_ok;
   logic [IDX_W-1:0]    idx_lo;

   // Only the low bits select a register once the range is known good
   assign idx_ok = disp_aeg_idx < pers_pkg::aeg_idx_t'(pers_pkg::NUM_AEG);
   assign idx_lo = disp_aeg_idx[IDX_W-1:0];

   // --------------------------------------------------
   // Register array
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      for (int i = 0; i < pers_pkg::NUM_AEG; i++) begin
         // Dispatch write wins over write-back
         if (disp_aeg_wr && idx_ok && idx_lo == IDX_W'(i)) begin
            aeg_q[i] <= disp_aeg_wr_data;
         end else if (i == pers_pkg::AEG_GVT && gvt_wr_en) begin
            // Zero-extended GVT
            aeg_q[i] <= pers_pkg::aeg_data_t'(gvt_wr_data);
         end
      end
   end

   // --------------------------------------------------
   // Read return and index check
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         disp_rtn_data_vld <= 1'b0;
         aeg_idx_err       <= 1'b0;
      end else begin
         disp_rtn_data_vld <= disp_aeg_rd;
         // Out of range on either strobe
         aeg_idx_err       <= (disp_aeg_rd || disp_aeg_wr) && !idx_ok;
      end
   end

   // Read data, zero for a bad index
   always_ff @(posedge clk) begin
      if (idx_ok) begin
         disp_rtn_data <= aeg_q[idx_lo];
      end else begin
         disp_rtn_data <= '0;
      end
   end

   // Steady for the whole run since the host is stalled
   assign aeg_base = aeg_q[pers_pkg::AEG_ADDR_BASE][$bits(pers_pkg::vadr_t)-1:0];
   assign aeg_len  = aeg_q[pers_pkg::AEG_EV_LEN][$bits(pers_pkg::ev_len_t)-1:0];

   // Host never reads and writes in one cycle
   a_no_rd_wr: assert property (@(posedge clk) disable iff (reset)
      !(disp_aeg_rd && disp_aeg_wr));

endmodule

//--- hw/pers_ctl.sv
`timescale 1ns/1ps

module pers_ctl (
   input  logic                clk,
   input  logic                reset,
   // Dispatch instruction
   input  logic                disp_inst_vld,
   input  pers_pkg::inst_t     disp_inst,
   input  logic [3:0]          aeid,
   // Status from register file and engine
   input  logic                aeg_idx_err,
   input  logic                gvt_done,
   input  pers_pkg::gvt_t      gvt_value,
   // CSR read request
   input  logic                csr_rd_vld,
   input  logic [15:0]         csr_address,
   // Engine start and GVT write-back
   output logic                run_start,
   output logic                gvt_wr_en,
   output pers_pkg::gvt_t      gvt_wr_data,
   // Dispatch status
   output logic                disp_idle,
   output logic                disp_stall,
   output logic [15:0]         disp_exception,
   output logic [17:0]         disp_aeg_cnt,
   // CSR read return
   output logic                csr_rd_ack,
   output pers_pkg::aeg_data_t csr_rd_data
);

   pers_pkg::ctl_state_t state_q;
   pers_pkg::ctl_state_t state_d;
   pers_pkg::gvt_t       gvt_q;
   pers_pkg::aeg_data_t  csr_data_d;
   logic                 run_inst;
   logic                 run_inst_q;
   logic                 unimpl_q;
   logic                 gvt_take;

   // --------------------------------------------------
   // Dispatch decode
   // --------------------------------------------------
   assign run_inst = disp_inst_vld && (disp_inst == pers_pkg::INST_RUN);

   always_ff @(posedge clk) begin
      if (reset) begin
         run_inst_q <= 1'b0;
         unimpl_q   <= 1'b0;
      end else begin
         run_inst_q <= run_inst;
         // Anything but the run instruction
         unimpl_q   <= disp_inst_vld && (disp_inst != pers_pkg::INST_RUN);
      end
   end

   // --------------------------------------------------
   // Run FSM
   // --------------------------------------------------
   // Result accepted only while running
   assign gvt_take = (state_q == pers_pkg::ctl_running) && gvt_done;

   always_comb begin
      state_d = state_q;
      case (state_q)
         pers_pkg::ctl_idle: begin
            if (run_inst_q) begin
               state_d = pers_pkg::ctl_running;
            end
         end
         pers_pkg::ctl_running: begin
            // Other engines skip the work and finish at once
            if (aeid != 4'h0 || gvt_done) begin
               state_d = pers_pkg::ctl_finished;
            end
         end
         pers_pkg::ctl_finished: state_d = pers_pkg::ctl_idle;
         default:                state_d = pers_pkg::ctl_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q   <= pers_pkg::ctl_idle;
         run_start <= 1'b0;
         gvt_wr_en <= 1'b0;
         gvt_q     <= '0;
      end else begin
         state_q   <= state_d;
         // High in the first running cycle, engine 0 only
         run_start <= (state_q == pers_pkg::ctl_idle) && run_inst_q && (aeid == 4'h0);
         // Write-back lands in AEG 4 at the end of the finished cycle
         gvt_wr_en <= gvt_take;
         if (gvt_take) begin
            gvt_q <= gvt_value;
         end
      end
   end

   assign gvt_wr_data = gvt_q;

   // --------------------------------------------------
   // Dispatch status
   // --------------------------------------------------
   assign disp_idle      = (state_q == pers_pkg::ctl_idle) && !run_inst_q;
   assign disp_stall     = (state_q != pers_pkg::ctl_idle) || run_inst || run_inst_q;
   // Bit 1 bad index, bit 0 unimplemented instruction
   assign disp_exception = {14'b0, aeg_idx_err, unimpl_q};
   assign disp_aeg_cnt   = 18'(pers_pkg::NUM_AEG);

   // --------------------------------------------------
   // CSR read port
   // --------------------------------------------------
   always_comb begin
      case (csr_address)
         pers_pkg::CSR_STATUS: csr_data_d = pers_pkg::aeg_data_t'(state_q);
         pers_pkg::CSR_GVT:    csr_data_d = pers_pkg::aeg_data_t'(gvt_q);
         default:              csr_data_d = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         csr_rd_ack <= 1'b0;
      end else begin
         csr_rd_ack <= csr_rd_vld;
      end
   end

   // Data only looked at with the ack
   always_ff @(posedge clk) begin
      csr_rd_data <= csr_data_d;
   end

   // Engine reports a result only during a run
   a_done_in_run: assert property (@(posedge clk) disable iff (reset)
      gvt_done |-> state_q == pers_pkg::ctl_running);

endmodule

//--- hw/ev_req_issue.sv
`timescale 1ns/1ps

module ev_req_issue #(
   parameter int MAX_OUTSTANDING = 8
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              run_start,
   input  pers_pkg::vadr_t   aeg_base,
   input  pers_pkg::ev_len_t aeg_len,
   // Memory request
   output logic              mc_rq_vld,
   output logic [2:0]        mc_rq_cmd,
   output logic [1:0]        mc_rq_size,
   output pers_pkg::vadr_t   mc_rq_vadr,
   input  logic              mc_rq_stall,
   // Response strobe, only counted here
   input  logic              mc_rs_vld
);

   localparam int PEND_W = $clog2(MAX_OUTSTANDING + 1);

   pers_pkg::vadr_t   base_q;
   pers_pkg::ev_len_t len_q;
   pers_pkg::ev_len_t rec_q;
   logic [PEND_W-1:0] pend_q;
   logic              reg_free;
   logic              room;
   logic              load;

   // Request register can take a new entry
   assign reg_free = !mc_rq_vld || !mc_rq_stall;
   // Pending covers in flight plus the one held here
   assign room     = pend_q < PEND_W'(MAX_OUTSTANDING);
   assign load     = reg_free && room && (rec_q != len_q) && !run_start;

   // --------------------------------------------------
   // Issue control
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         mc_rq_vld <= 1'b0;
         len_q     <= '0;
         rec_q     <= '0;
         pend_q    <= '0;
      end else begin
         if (run_start) begin
            len_q     <= aeg_len;
            rec_q     <= '0;
            mc_rq_vld <= 1'b0;
         end else if (reg_free) begin
            mc_rq_vld <= load;
            if (load) begin
               rec_q <= rec_q + 1'b1;
            end
         end
         // Loaded until its response comes back
         case ({load, mc_rs_vld})
            2'b10:   pend_q <= pend_q + 1'b1;
            2'b01:   pend_q <= pend_q - 1'b1;
            default: pend_q <= pend_q;
         endcase
      end
   end

   // Base plus 8 bytes per record
   always_ff @(posedge clk) begin
      if (run_start) begin
         base_q <= aeg_base;
      end
      if (load) begin
         mc_rq_vadr <= base_q + {13'b0, rec_q, 3'b000};
      end
   end

   assign mc_rq_cmd  = pers_pkg::MC_CMD_RD;
   assign mc_rq_size = pers_pkg::MC_SIZE_64;

   // Held request keeps its address
   a_rq_hold: assert property (@(posedge clk) disable iff (reset)
      mc_rq_vld && mc_rq_stall |=> mc_rq_vld && $stable(mc_rq_vadr));

endmodule

//--- hw/gvt_reduce.sv
`timescale 1ns/1ps

module gvt_reduce #(
   parameter int MAX_OUTSTANDING = 8
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                run_start,
   input  pers_pkg::ev_len_t   aeg_len,
   // Memory response
   input  logic                mc_rs_vld,
   input  pers_pkg::aeg_data_t mc_rs_data,
   // Result
   output logic                gvt_done,
   output pers_pkg::gvt_t      gvt_value
);

   pers_pkg::ev_len_t len_q;
   pers_pkg::ev_len_t cnt_q;
   pers_pkg::ev_len_t cnt_next;
   pers_pkg::gvt_t    rs_ts;
   logic              busy_q;
   logic              take;
   logic              last;

   // Timestamp sits in the low bits of the record
   assign rs_ts    = mc_rs_data[$bits(pers_pkg::gvt_t)-1:0];
   assign take     = busy_q && mc_rs_vld;
   assign cnt_next = cnt_q + 1'b1;
   assign last     = take && (cnt_next == len_q);

   // --------------------------------------------------
   // Response count and done
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q   <= 1'b0;
         cnt_q    <= '0;
         gvt_done <= 1'b0;
      end else begin
         // Empty table finishes right after start
         gvt_done <= (run_start && aeg_len == '0) || last;
         if (run_start) begin
            cnt_q  <= '0;
            busy_q <= aeg_len != '0;
         end else if (take) begin
            cnt_q <= cnt_next;
            if (last) begin
               busy_q <= 1'b0;
            end
         end
      end
   end

   // Running minimum over the responses in any order
   always_ff @(posedge clk) begin
      if (run_start) begin
         len_q     <= aeg_len;
         gvt_value <= pers_pkg::GVT_EMPTY;
      end else if (take && rs_ts < gvt_value) begin
         gvt_value <= rs_ts;
      end
   end

   // Memory never returns more than was asked for
   a_no_extra_rs: assert property (@(posedge clk) disable iff (reset)
      mc_rs_vld |-> busy_q);

endmodule

//--- hw/pers_top.sv
`timescale 1ns/1ps

module pers_top #(
   parameter int MAX_OUTSTANDING = 8
) (
   input  logic                clk,
   input  logic                reset,
   // --------------------------------------------------
   // Dispatch
   // --------------------------------------------------
   input  logic                disp_inst_vld,
   input  pers_pkg::inst_t     disp_inst,
   input  pers_pkg::aeg_idx_t  disp_aeg_idx,
   input  logic                disp_aeg_rd,
   input  logic                disp_aeg_wr,
   input  pers_pkg::aeg_data_t disp_aeg_wr_data,
   output logic [17:0]         disp_aeg_cnt,
   output logic [15:0]         disp_exception,
   output logic                disp_idle,
   output logic                disp_stall,
   output logic                disp_rtn_data_vld,
   output pers_pkg::aeg_data_t disp_rtn_data,
   // --------------------------------------------------
   // CSR debug
   // --------------------------------------------------
   input  logic                csr_rd_vld,
   input  logic [15:0]         csr_address,
   output logic                csr_rd_ack,
   output pers_pkg::aeg_data_t csr_rd_data,
   // --------------------------------------------------
   // Memory controller port
   // --------------------------------------------------
   output logic                mc_rq_vld,
   output logic [2:0]          mc_rq_cmd,
   output logic [1:0]          mc_rq_size,
   output pers_pkg::vadr_t     mc_rq_vadr,
   input  logic                mc_rq_stall,
   input  logic                mc_rs_vld,
   input  pers_pkg::aeg_data_t mc_rs_data,
   // Engine identity
   input  logic [3:0]          aeid
);

   // Control to engine
   logic              run_start;
   // Register file to engine
   pers_pkg::vadr_t   aeg_base;
   pers_pkg::ev_len_t aeg_len;
   logic              aeg_idx_err;
   // Engine result back to control
   logic              gvt_done;
   pers_pkg::gvt_t    gvt_value;
   // Write-back into AEG 4
   logic              gvt_wr_en;
   pers_pkg::gvt_t    gvt_wr_data;

   aeg_regs i_aeg_regs (
      .clk               (clk),
      .reset             (reset),
      .disp_aeg_idx      (disp_aeg_idx),
      .disp_aeg_rd       (disp_aeg_rd),
      .disp_aeg_wr       (disp_aeg_wr),
      .disp_aeg_wr_data  (disp_aeg_wr_data),
      .gvt_wr_en         (gvt_wr_en),
      .gvt_wr_data       (gvt_wr_data),
      .disp_rtn_data_vld (disp_rtn_data_vld),
      .disp_rtn_data     (disp_rtn_data),
      .aeg_idx_err       (aeg_idx_err),
      .aeg_base          (aeg_base),
      .aeg_len           (aeg_len)
   );

   pers_ctl i_pers_ctl (
      .clk            (clk),
      .reset          (reset),
      .disp_inst_vld  (disp_inst_vld),
      .disp_inst      (disp_inst),
      .aeid           (aeid),
      .aeg_idx_err    (aeg_idx_err),
      .gvt_done       (gvt_done),
      .gvt_value      (gvt_value),
      .csr_rd_vld     (csr_rd_vld),
      .csr_address    (csr_address),
      .run_start      (run_start),
      .gvt_wr_en      (gvt_wr_en),
      .gvt_wr_data    (gvt_wr_data),
      .disp_idle      (disp_idle),
      .disp_stall     (disp_stall),
      .disp_exception (disp_exception),
      .disp_aeg_cnt   (disp_aeg_cnt),
      .csr_rd_ack     (csr_rd_ack),
      .csr_rd_data    (csr_rd_data)
   );

   // Stage 1, request issue
   ev_req_issue #(
      .MAX_OUTSTANDING (MAX_OUTSTANDING)
   ) i_ev_req_issue (
      .clk         (clk),
      .reset       (reset),
      .run_start   (run_start),
      .aeg_base    (aeg_base),
      .aeg_len     (aeg_len),
      .mc_rq_vld   (mc_rq_vld),
      .mc_rq_cmd   (mc_rq_cmd),
      .mc_rq_size  (mc_rq_size),
      .mc_rq_vadr  (mc_rq_vadr),
      .mc_rq_stall (mc_rq_stall),
      .mc_rs_vld   (mc_rs_vld)
   );

   // Stage 2, minimum reduction
   gvt_reduce #(
      .MAX_OUTSTANDING (MAX_OUTSTANDING)
   ) i_gvt_reduce (
      .clk        (clk),
      .reset      (reset),
      .run_start  (run_start),
      .aeg_len    (aeg_len),
      .mc_rs_vld  (mc_rs_vld),
      .mc_rs_data (mc_rs_data),
      .gvt_done   (gvt_done),
      .gvt_value  (gvt_value)
   );

endmodule

//--- dv/tb_pers_top.sv
`timescale 1ns/1ps

module tb_pers_top;

   localparam int MAX_OUTSTANDING = 4;
   localparam logic [31:0] SEED = 32'h4627_fcee;
   localparam int LEN_STREAM = 12;
   localparam int LEN_GVT = 40;
   localparam int LEN_AEID = 5;
   // Record count times 20 cycles plus 100 for each of the six tests
   localparam int WATCHDOG_CYCLES = (LEN_STREAM + LEN_GVT + LEN_AEID) * 20 + 6 * 100;

   logic                clk;
   logic                reset;
   logic                disp_inst_vld;
   pers_pkg::inst_t     disp_inst;
   pers_pkg::aeg_idx_t  disp_aeg_idx;
   logic                disp_aeg_rd;
   logic                disp_aeg_wr;
   pers_pkg::aeg_data_t disp_aeg_wr_data;
   logic [17:0]         disp_aeg_cnt;
   logic [15:0]         disp_exception;
   logic                disp_idle;
   logic                disp_stall;
   logic                disp_rtn_data_vld;
   pers_pkg::aeg_data_t disp_rtn_data;
   logic                csr_rd_vld;
   logic [15:0]         csr_address;
   logic                csr_rd_ack;
   pers_pkg::aeg_data_t csr_rd_data;
   logic                mc_rq_vld;
   logic [2:0]          mc_rq_cmd;
   logic [1:0]          mc_rq_size;
   pers_pkg::vadr_t     mc_rq_vadr;
   logic                mc_rq_stall;
   logic                mc_rs_vld;
   pers_pkg::aeg_data_t mc_rs_data;
   logic [3:0]          aeid;

   // Expected state, kept by the stimulus
   pers_pkg::aeg_data_t shadow [pers_pkg::NUM_AEG];
   pers_pkg::gvt_t      gvt_exp;
   pers_pkg::vadr_t     run_base;
   pers_pkg::ev_len_t   exp_len;
   logic                in_run;
   // Expected responses lag their strobes by one cycle
   pers_pkg::aeg_data_t rtn_exp;
   pers_pkg::aeg_data_t csr_exp;
   logic [15:0]         exc_exp;
   pers_pkg::ev_len_t   rq_cnt;
   pers_pkg::vadr_t     rq_exp_vadr;
   // Memory model state
   logic [31:0]         stim_lfsr;
   logic [31:0]         mem_lfsr;
   pers_pkg::vadr_t     pend_adr [$];
   int                  pend_due [$];
   int                  in_flight;
   int                  cyc;
   // Bookkeeping
   int                  err_cnt;
   int                  err_mark;
   int                  test_cnt;
   int                  fail_cnt;

   pers_top #(
      .MAX_OUTSTANDING (MAX_OUTSTANDING)
   ) i_pers_top (
      .clk               (clk),
      .reset             (reset),
      .disp_inst_vld     (disp_inst_vld),
      .disp_inst         (disp_inst),
      .disp_aeg_idx      (disp_aeg_idx),
      .disp_aeg_rd       (disp_aeg_rd),
      .disp_aeg_wr       (disp_aeg_wr),
      .disp_aeg_wr_data  (disp_aeg_wr_data),
      .disp_aeg_cnt      (disp_aeg_cnt),
      .disp_exception    (disp_exception),
      .disp_idle         (disp_idle),
      .disp_stall        (disp_stall),
      .disp_rtn_data_vld (disp_rtn_data_vld),
      .disp_rtn_data     (disp_rtn_data),
      .csr_rd_vld        (csr_rd_vld),
      .csr_address       (csr_address),
      .csr_rd_ack        (csr_rd_ack),
      .csr_rd_data       (csr_rd_data),
      .mc_rq_vld         (mc_rq_vld),
      .mc_rq_cmd         (mc_rq_cmd),
      .mc_rq_size        (mc_rq_size),
      .mc_rq_vadr        (mc_rq_vadr),
      .mc_rq_stall       (mc_rq_stall),
      .mc_rs_vld         (mc_rs_vld),
      .mc_rs_data        (mc_rs_data),
      .aeid              (aeid)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // --------------------------------------------------
   // LFSR and record contents
   // --------------------------------------------------
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One step per bit taken
   function automatic logic [63:0] take_bits(inout logic [31:0] st, input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         st = lfsr_next(st);
         v = {v[62:0], st[0]};
      end
      return v;
   endfunction

   // Scrambled address word with the timestamp in the low 16 bits
   function automatic pers_pkg::aeg_data_t rec_value(input pers_pkg::vadr_t a);
      logic [31:0] s;
      logic [31:0] hi;
      s = a[34:3] ^ a[47:16] ^ 32'h5a5a_3c3c;
      for (int i = 0; i < 24; i++) begin
         s = lfsr_next(s);
      end
      hi = s;
      for (int i = 0; i < 8; i++) begin
         s = lfsr_next(s);
      end
      return {hi, s};
   endfunction

   task automatic note_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
   endtask

   task automatic note_failure(input string what);
      $display("Error at %0t ns: %s", $time, what);
      err_cnt++;
   endtask

   // --------------------------------------------------
   // Reference values
   // --------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         exc_exp <= '0;
         rq_cnt  <= '0;
      end else begin
         exc_exp <= {14'b0,
                     (disp_aeg_rd || disp_aeg_wr) &&
                     (disp_aeg_idx >= pers_pkg::aeg_idx_t'(pers_pkg::NUM_AEG)),
                     disp_inst_vld && (disp_inst != pers_pkg::INST_RUN)};
         // Record number restarts with each run instruction
         if (disp_inst_vld && disp_inst == pers_pkg::INST_RUN) begin
            rq_cnt <= '0;
         end else if (mc_rq_vld && !mc_rq_stall) begin
            rq_cnt <= rq_cnt + 32'd1;
         end
      end
      if (disp_aeg_idx < pers_pkg::aeg_idx_t'(pers_pkg::NUM_AEG)) begin
         rtn_exp <= shadow[disp_aeg_idx[2:0]];
      end else begin
         rtn_exp <= '0;
      end
      // Status is read only while idle so the state code is zero
      csr_exp <= (csr_address == pers_pkg::CSR_GVT) ? pers_pkg::aeg_data_t'(gvt_exp) : '0;
   end

   assign rq_exp_vadr = run_base + pers_pkg::vadr_t'({rq_cnt, 3'b000});

   // --------------------------------------------------
   // Checking
   // --------------------------------------------------
   a_rtn_vld: assert property (@(posedge clk) disable iff (reset)
      disp_rtn_data_vld == $past(disp_aeg_rd))
      else note_failure("disp_rtn_data_vld not exactly one cycle after disp_aeg_rd");
   a_rtn_data: assert property (@(posedge clk) disable iff (reset)
      disp_rtn_data_vld |-> disp_rtn_data == rtn_exp)
      else note_mismatch("disp_rtn_data", $sampled(disp_rtn_data), $sampled(rtn_exp));
   a_exc: assert property (@(posedge clk) disable iff (reset)
      disp_exception == exc_exp)
      else note_mismatch("disp_exception", 64'($sampled(disp_exception)),
                         64'($sampled(exc_exp)));
   a_aeg_cnt: assert property (@(posedge clk) disable iff (reset)
      disp_aeg_cnt == 18'(pers_pkg::NUM_AEG))
      else note_mismatch("disp_aeg_cnt", 64'($sampled(disp_aeg_cnt)), 64'(pers_pkg::NUM_AEG));
   a_csr_ack: assert property (@(posedge clk) disable iff (reset)
      csr_rd_ack == $past(csr_rd_vld))
      else note_failure("csr_rd_ack not exactly one cycle after csr_rd_vld");
   a_csr_data: assert property (@(posedge clk) disable iff (reset)
      csr_rd_ack |-> csr_rd_data == csr_exp)
      else note_mismatch("csr_rd_data", $sampled(csr_rd_data), $sampled(csr_exp));
   // Unimplemented instruction leaves the engine idle
   a_unimpl_idle: assert property (@(posedge clk) disable iff (reset)
      disp_inst_vld && disp_inst != pers_pkg::INST_RUN && disp_idle |=> disp_idle)
      else note_failure("disp_idle dropped after an unimplemented instruction");
   a_stall_run: assert property (@(posedge clk) disable iff (reset)
      (in_run && !disp_idle) || (disp_inst_vld && disp_inst == pers_pkg::INST_RUN)
      |-> disp_stall)
      else note_failure("disp_stall low during a run");
   a_stall_idle: assert property (@(posedge clk) disable iff (reset)
      disp_idle && !disp_inst_vld |-> !disp_stall)
      else note_failure("disp_stall high while idle");
   // Request stream
   a_rq_kind: assert property (@(posedge clk) disable iff (reset)
      mc_rq_vld && !mc_rq_stall |->
      mc_rq_cmd == pers_pkg::MC_CMD_RD && mc_rq_size == pers_pkg::MC_SIZE_64)
      else note_failure("memory request is not a 64-bit read");
   a_rq_vadr: assert property (@(posedge clk) disable iff (reset)
      mc_rq_vld && !mc_rq_stall |-> mc_rq_vadr == rq_exp_vadr)
      else note_mismatch("mc_rq_vadr", 64'($sampled(mc_rq_vadr)), 64'($sampled(rq_exp_vadr)));
   a_rq_count: assert property (@(posedge clk) disable iff (reset)
      mc_rq_vld && !mc_rq_stall |-> rq_cnt < exp_len)
      else note_failure("memory request beyond the end of the table");
   a_rq_hold: assert property (@(posedge clk) disable iff (reset)
      mc_rq_vld && mc_rq_stall |=> mc_rq_vld && $stable(mc_rq_vadr) &&
      $stable(mc_rq_cmd) && $stable(mc_rq_size))
      else note_failure("memory request changed while stalled");
   a_in_flight: assert property (@(posedge clk) disable iff (reset)
      in_flight <= MAX_OUTSTANDING)
      else note_failure("too many memory reads in flight");
   // All records requested by the first idle cycle of a run
   a_run_end: assert property (@(posedge clk) disable iff (reset)
      in_run && disp_idle |-> rq_cnt == exp_len)
      else note_mismatch("request count", 64'($sampled(rq_cnt)), 64'($sampled(exp_len)));

   // --------------------------------------------------
   // Memory model
   // --------------------------------------------------
   initial begin
      logic [63:0] draw;
      int          lat;
      int          hit;
      mem_lfsr    = SEED;
      in_flight   = 0;
      cyc         = 0;
      mc_rq_stall = 1'b0;
      mc_rs_vld   = 1'b0;
      mc_rs_data  = '0;
      forever begin
         @(posedge clk);
         #1;
         cyc++;
         // Stall one cycle in four
         draw = take_bits(mem_lfsr, 2);
         mc_rq_stall = (draw[1:0] == 2'b11);
         // Transfer happens at the coming edge
         if (mc_rq_vld && !mc_rq_stall) begin
            lat = 1 + int'(take_bits(mem_lfsr, 3) % 64'd6);
            pend_adr.push_back(mc_rq_vadr);
            pend_due.push_back(cyc + lat);
            in_flight++;
         end
         hit = -1;
         for (int k = 0; k < pend_due.size(); k++) begin
            if (hit < 0 && pend_due[k] <= cyc) begin
               hit = k;
            end
         end
         mc_rs_vld = 1'b0;
         if (hit >= 0) begin
            mc_rs_vld  = 1'b1;
            mc_rs_data = rec_value(pend_adr[hit]);
            pend_adr.delete(hit);
            pend_due.delete(hit);
            in_flight--;
         end
      end
   end

   // --------------------------------------------------
   // Stimulus tasks
   // --------------------------------------------------
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic aeg_write(input int idx, input pers_pkg::aeg_data_t data);
      disp_aeg_idx     = pers_pkg::aeg_idx_t'(idx);
      disp_aeg_wr_data = data;
      disp_aeg_wr      = 1'b1;
      if (idx < pers_pkg::NUM_AEG) begin
         shadow[idx] = data;
      end
      step();
      disp_aeg_wr = 1'b0;
   endtask

   task automatic aeg_read(input int idx);
      disp_aeg_idx = pers_pkg::aeg_idx_t'(idx);
      disp_aeg_rd  = 1'b1;
      step();
      disp_aeg_rd = 1'b0;
      step();
   endtask

   task automatic csr_read(input logic [15:0] adr);
      csr_address = adr;
      csr_rd_vld  = 1'b1;
      step();
      csr_rd_vld = 1'b0;
      step();
   endtask

   // Program a table, run it and read the result back
   task automatic run_table(input int len, input logic [3:0] id);
      pers_pkg::vadr_t     base;
      pers_pkg::gvt_t      min_ts;
      pers_pkg::aeg_data_t rec;
      int                  bound;
      int                  waited;
      base = pers_pkg::vadr_t'({take_bits(stim_lfsr, 40), 3'b000});
      aeg_write(pers_pkg::AEG_ADDR_BASE, pers_pkg::aeg_data_t'(base));
      aeg_write(pers_pkg::AEG_EV_LEN, pers_pkg::aeg_data_t'(len));
      // Expected GVT over the records just programmed
      min_ts = pers_pkg::GVT_EMPTY;
      for (int i = 0; i < len; i++) begin
         rec = rec_value(base + pers_pkg::vadr_t'(8 * i));
         if (rec[15:0] < min_ts) begin
            min_ts = rec[15:0];
         end
      end
      aeid     = id;
      run_base = base;
      exp_len  = (id == 4'h0) ? pers_pkg::ev_len_t'(len) : '0;
      if (id == 4'h0) begin
         gvt_exp = min_ts;
         shadow[pers_pkg::AEG_GVT] = pers_pkg::aeg_data_t'(min_ts);
      end
      disp_inst     = pers_pkg::INST_RUN;
      disp_inst_vld = 1'b1;
      step();
      disp_inst_vld = 1'b0;
      in_run        = 1'b1;
      bound  = len * 20 + 100;
      waited = 0;
      while (!disp_idle && waited < bound) begin
         step();
         waited++;
      end
      if (!disp_idle) begin
         note_failure("run did not return to idle");
      end
      // Let the end-of-run check see the first idle cycle
      step();
      in_run = 1'b0;
      aeg_read(pers_pkg::AEG_GVT);
      csr_read(pers_pkg::CSR_GVT);
   endtask

   task automatic open_test();
      err_mark = err_cnt;
   endtask

   task automatic close_test(input string name);
      step();
      step();
      test_cnt++;
      if (err_cnt == err_mark) begin
         $display("PASS  %s", name);
      end else begin
         fail_cnt++;
         $display("FAIL  %s", name);
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      reset            = 1'b1;
      disp_inst_vld    = 1'b0;
      disp_inst        = '0;
      disp_aeg_idx     = '0;
      disp_aeg_rd      = 1'b0;
      disp_aeg_wr      = 1'b0;
      disp_aeg_wr_data = '0;
      csr_rd_vld       = 1'b0;
      csr_address      = '0;
      aeid             = 4'h0;
      stim_lfsr        = SEED;
      gvt_exp          = '0;
      run_base         = '0;
      exp_len          = '0;
      in_run           = 1'b0;
      err_cnt          = 0;
      err_mark         = 0;
      test_cnt         = 0;
      fail_cnt         = 0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      open_test();
      for (int i = 0; i < pers_pkg::NUM_AEG; i++) begin
         aeg_write(i, take_bits(stim_lfsr, 64));
      end
      for (int i = 0; i < pers_pkg::NUM_AEG; i++) begin
         aeg_read(i);
      end
      aeg_read(9);
      close_test("AEG write and read");

      open_test();
      disp_inst     = 5'd5;
      disp_inst_vld = 1'b1;
      step();
      disp_inst_vld = 1'b0;
      step();
      // GVT is zero out of reset
      csr_read(pers_pkg::CSR_STATUS);
      csr_read(pers_pkg::CSR_GVT);
      csr_read(16'h7);
      close_test("unimplemented instruction");

      open_test();
      run_table(LEN_STREAM, 4'h0);
      close_test("request stream");

      open_test();
      run_table(LEN_GVT, 4'h0);
      close_test("GVT result");

      open_test();
      run_table(0, 4'h0);
      close_test("empty table");

      open_test();
      run_table(LEN_AEID, 4'h3);
      close_test("nonzero aeid");

      $display("Tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Ends a hung run
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- verilog.f
hw/pers_pkg.sv
hw/aeg_regs.sv
hw/pers_ctl.sv
hw/ev_req_issue.sv
hw/gvt_reduce.sv
hw/pers_top.sv
dv/tb_pers_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module tb_pers_top \
   -Mdir obj_dir

out=$(./obj_dir/Vtb_pers_top)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
   exit 0
fi
exit 1
